// File: tb.f
verilog/rdpath_pkg.sv
verilog/irq_cell.sv
verilog/sysreg_decode.sv
verilog/input_mux.sv
verilog/rdpath_top.sv
bench/rdpath_chk.sv
bench/tb_rdpath.sv

// File: Bender.yml
package:
  name: rdpath

sources:
  - files:
      - verilog/rdpath_pkg.sv
      - verilog/irq_cell.sv
      - verilog/sysreg_decode.sv
      - verilog/input_mux.sv
      - verilog/rdpath_top.sv
  - target: test
    files:
      - bench/rdpath_chk.sv
      - bench/tb_rdpath.sv

// File: bench/tb_rdpath.sv
`timescale 1ns/1ps

module tb_rdpath import rdpath_pkg::*; ();

   localparam int PERIOD          = 40;  // ns
   localparam int RESET_CYCLES    = 8;
   localparam int RAND_CYCLES     = 400;
   localparam int DIRECTED_CYCLES = 20;  // Post-reset reads, corner cases, drain
   localparam int STIM_CYCLES     = RESET_CYCLES + RAND_CYCLES + DIRECTED_CYCLES;

   logic               clk;
   logic               rst;
   bus_req_t           req;
   logic [XLEN-1:0]    sram_data;
   logic [XLEN-1:0]    io_data;
   logic [NUM_IRQ-1:0] irq_event;
   rd_rsp_t            rsp;
   logic               sysreg_ack;
   logic               irq_req;
   integer             seed;

   // Reference model state
   logic [NUM_IRQ-1:0] exp_en;
   logic [NUM_IRQ-1:0] exp_pend;
   logic               exp_mie;
   logic               exp_mpie;
   logic               exp_valid;
   logic [XLEN-1:0]    exp_data;

   rdpath_top rdpath_top_i (.*);

   bind rdpath_top rdpath_chk rdpath_chk_i (.*); // Protocol checks

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // ========================================
   // Failure reporting
   // ========================================

   task automatic stop_with_failure();
      $display("Done: errors found");
      $fatal(1, "Simulation stopped on first failure");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      $display("[ERROR] %s expected %h actual %h", name, exp_v, act_v);
      stop_with_failure();
   endtask

   // ========================================
   // Reference model
   // ========================================

   // Word a read should return, built from the register map
   function automatic logic [31:0] expected_word(input logic [3:0] region,
                                                 input logic [31:0] sram_v,
                                                 input logic [31:0] io_v);
      logic [31:0] w;
      w = '0;
      case (region)
         REGION_IO: w = io_v;
         REGION_MIP: for (int i = 0; i < NUM_IRQ; i++) w[IRQ_POS[i]] = exp_pend[i];
         REGION_MIE: for (int i = 0; i < NUM_IRQ; i++) w[IRQ_POS[i]] = exp_en[i];
         REGION_MSTATUS: begin
            w[MSTATUS_MIE_POS]    = exp_mie;
            w[MSTATUS_MPIE_POS]   = exp_mpie;
            w[MSTATUS_MPP_POS[0]] = 1'b1; // Machine mode only
            w[MSTATUS_MPP_POS[1]] = 1'b1;
         end
         default: w = sram_v;
      endcase
      return w;
   endfunction

   always @(posedge clk) begin
      if (rst) begin
         exp_en    <= '0;
         exp_pend  <= '0;
         exp_mie   <= 1'b0;
         exp_mpie  <= 1'b0;
         exp_valid <= 1'b0;
      end else begin
         for (int i = 0; i < NUM_IRQ; i++) begin
            if (irq_event[i]) exp_pend[i] <= 1'b1; // Event beats a software clear
            else if (req.stb && req.we && req.addr[30:27] == REGION_MIP)
               exp_pend[i] <= req.wdata[IRQ_POS[i]];
            if (req.stb && req.we && req.addr[30:27] == REGION_MIE)
               exp_en[i] <= req.wdata[IRQ_POS[i]];
         end
         if (req.stb && req.we && req.addr[30:27] == REGION_MSTATUS) begin
            exp_mie  <= req.wdata[MSTATUS_MIE_POS];
            exp_mpie <= req.wdata[MSTATUS_MPIE_POS];
         end
         exp_valid <= req.stb & ~req.we; // Reads only
         if (req.stb && !req.we) exp_data <= expected_word(req.addr[30:27], sram_data, io_data);
      end
   end

   // ========================================
   // Checks against the model
   // ========================================

   a_valid: assert property (@(posedge clk) disable iff (rst) rsp.valid == exp_valid)
      else report_mismatch("rsp.valid", $sampled(exp_valid), $sampled(rsp.valid));
   a_data: assert property (@(posedge clk) disable iff (rst) rsp.valid |-> rsp.data == exp_data)
      else report_mismatch("rsp.data", $sampled(exp_data), $sampled(rsp.data));
   a_irq: assert property (@(posedge clk) disable iff (rst)
                           irq_req == (exp_mie & |(exp_en & exp_pend)))
      else report_mismatch("irq_req", $sampled(exp_mie & |(exp_en & exp_pend)),
                           $sampled(irq_req));
   a_pend: assert property (@(posedge clk) disable iff (rst)
                            rdpath_top_i.irq_pending == exp_pend)
      else report_mismatch("irq_pending", $sampled(exp_pend),
                           $sampled(rdpath_top_i.irq_pending));

   // Stop at the first protocol violation
   always @(negedge clk) begin
      if (rdpath_top_i.rdpath_chk_i.check_failed) begin
         $display("A protocol assertion in rdpath_chk failed");
         stop_with_failure();
      end
   end

   // ========================================
   // Stimulus
   // ========================================

   // One bus cycle, inputs change on the falling edge
   task automatic drive(input logic stb, input logic we, input logic [3:0] region,
                        input logic [31:0] wdata, input logic [NUM_IRQ-1:0] events);
      @(negedge clk);
      req.stb          = stb;
      req.we           = we;
      req.addr         = $random(seed);
      req.addr[30:27]  = region;
      req.wdata        = wdata;
      sram_data        = $random(seed); // Fresh source data every cycle
      io_data          = $random(seed);
      irq_event        = events;
   endtask

   initial begin
      logic [31:0] pick;
      logic [3:0]  region;
      seed      = 32'h0fc23e11;
      rst       = 1'b1;
      req       = '0;
      sram_data = '0;
      io_data   = '0;
      irq_event = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      drive(1'b1, 1'b0, REGION_MIP, '0, '0);      // Reset values
      drive(1'b1, 1'b0, REGION_MIE, '0, '0);
      drive(1'b1, 1'b0, REGION_MSTATUS, '0, '0);  // MPP reads as ones
      for (int n = 0; n < RAND_CYCLES; n++) begin
         pick   = $random(seed);
         region = pick[11:8];
         if (region[3:2] == 2'b11) region[2] = 1'b0; // Force an SRAM region
         case (pick[2:0])
            3'd3:    region = REGION_IO;
            3'd4:    region = REGION_MIP;
            3'd5:    region = REGION_MIE;
            3'd6:    region = REGION_MSTATUS;
            default: ;
         endcase
         drive(pick[3] | pick[4], pick[5], region, $random(seed),
               pick[20:16] & pick[25:21] & pick[30:26]); // Sparse events
      end
      drive(1'b1, 1'b1, REGION_MIP, '0, 5'b10101);  // Clear racing events
      drive(1'b1, 1'b0, REGION_MIP, '0, '0);
      drive(1'b1, 1'b1, REGION_MIE, '1, '0);        // Only IRQ_POS bits stick
      drive(1'b1, 1'b0, REGION_MIE, '0, '0);
      drive(1'b1, 1'b1, REGION_MSTATUS, '1, '0);
      drive(1'b1, 1'b0, REGION_MSTATUS, '0, '0);
      drive(1'b1, 1'b0, 4'h2, '0, '0);              // Back-to-back SRAM, IO, SRAM
      drive(1'b1, 1'b0, REGION_IO, '0, '0);
      drive(1'b1, 1'b0, 4'h9, '0, '0);
      drive(1'b0, 1'b0, 4'h0, '0, '0);
      drive(1'b0, 1'b0, 4'h0, '0, '0);
      @(negedge clk);
      if (rdpath_top_i.rdpath_chk_i.check_failed) begin
         $display("A protocol assertion in rdpath_chk failed");
         stop_with_failure();
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

   // Watchdog sized from the stimulus length
   initial begin
      #((STIM_CYCLES + 50) * PERIOD);
      $display("Timeout, the stimulus did not finish in time");
      stop_with_failure();
   end

endmodule

// File: bench/rdpath_chk.sv
`timescale 1ns/1ps

module rdpath_chk import rdpath_pkg::*; (
   input logic     clk,
   input logic     rst,
   input bus_req_t req,
   input rd_rsp_t  rsp,
   input logic     sysreg_ack
);

   logic [3:0] region;
   logic       is_reg;     // One of MIP, MIE, MSTATUS
   logic       rd_stb;
   logic       check_failed;

   initial check_failed = 1'b0; // Sticky, set by any failed assertion

   assign region = req.addr[30:27];
   assign is_reg = (region == REGION_MIP) || (region == REGION_MIE) ||
                   (region == REGION_MSTATUS);
   assign rd_stb = req.stb & ~req.we;

   // ========================================
   // Acknowledge
   // ========================================

   a_ack_stb: assert property (@(posedge clk) disable iff (rst) sysreg_ack |-> req.stb)
      else begin
         $error("sysreg_ack high without a strobe");
         check_failed = 1'b1;
      end

   a_ack_region: assert property (@(posedge clk) disable iff (rst)
                                  req.stb |-> sysreg_ack == is_reg)
      else begin
         $error("sysreg_ack does not match the region");
         check_failed = 1'b1;
      end

   // ========================================
   // Response timing
   // ========================================

   a_rsp_follows: assert property (@(posedge clk) disable iff (rst) rd_stb |=> rsp.valid)
      else begin
         $error("No response one cycle after a read");
         check_failed = 1'b1;
      end

   a_rsp_cause: assert property (@(posedge clk) disable iff (rst) rsp.valid |-> $past(rd_stb))
      else begin
         $error("Response without a read strobe");
         check_failed = 1'b1;
      end

   a_rsp_reset: assert property (@(posedge clk) $past(rst) |-> !rsp.valid)
      else begin
         $error("rsp.valid set out of reset");
         check_failed = 1'b1;
      end

endmodule

// File: verilog/rdpath_top.sv
`timescale 1ns/1ps

module rdpath_top import rdpath_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  bus_req_t           req,
   input  logic [XLEN-1:0]    sram_data,
   input  logic [XLEN-1:0]    io_data,
   input  logic [NUM_IRQ-1:0] irq_event,  // One pulse line per source
   output rd_rsp_t            rsp,
   output logic               sysreg_ack,
   output logic               irq_req
);

   // Decoder to cells
   logic [NUM_IRQ-1:0] en_wr;
   logic [NUM_IRQ-1:0] pend_wr;
   logic [NUM_IRQ-1:0] wbits;

   // Cells to mux and decoder
   logic [NUM_IRQ-1:0] irq_enable;
   logic [NUM_IRQ-1:0] irq_pending;

   logic mstatus_mie;
   logic mstatus_mpie;

   // ========================================
   // Write decode and MSTATUS
   // ========================================

   sysreg_decode sysreg_decode_i (
      .clk          (clk),
      .rst          (rst),
      .req          (req),
      .irq_enable   (irq_enable),
      .irq_pending  (irq_pending),
      .en_wr        (en_wr),
      .pend_wr      (pend_wr),
      .wbits        (wbits),
      .mstatus_mie  (mstatus_mie),
      .mstatus_mpie (mstatus_mpie),
      .sysreg_ack   (sysreg_ack),
      .irq_req      (irq_req)
   );

   // ========================================
   // Interrupt cells
   // ========================================

   // Index order follows IRQ_POS
   for (genvar i = 0; i < NUM_IRQ; i++) begin : g_irq
      irq_cell irq_cell_i (
         .clk       (clk),
         .rst       (rst),
         .irq_event (irq_event[i]),
         .en_wr     (en_wr[i]),
         .pend_wr   (pend_wr[i]),
         .wbit      (wbits[i]),
         .enable    (irq_enable[i]),
         .pending   (irq_pending[i])
      );
   end

   // Read side
   input_mux input_mux_i (
      .clk          (clk),
      .rst          (rst),
      .req          (req),
      .sram_data    (sram_data),
      .io_data      (io_data),
      .irq_enable   (irq_enable),
      .irq_pending  (irq_pending),
      .mstatus_mie  (mstatus_mie),
      .mstatus_mpie (mstatus_mpie),
      .rsp          (rsp)
   );

endmodule

// File: verilog/input_mux.sv
`timescale 1ns/1ps

module input_mux import rdpath_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  bus_req_t           req,
   input  logic [XLEN-1:0]    sram_data,   // SRAM read data
   input  logic [XLEN-1:0]    io_data,     // External input port
   input  logic [NUM_IRQ-1:0] irq_enable,
   input  logic [NUM_IRQ-1:0] irq_pending,
   input  logic               mstatus_mie,
   input  logic               mstatus_mpie,
   output rd_rsp_t            rsp
);

   // ========================================
   // Register words
   // ========================================

   logic [XLEN-1:0] mip_word;
   logic [XLEN-1:0] mie_word;
   logic [XLEN-1:0] mstatus_word;

   // Scatter cell bits to their architectural positions
   always_comb begin
      mip_word = '0;
      mie_word = '0;
      for (int i = 0; i < NUM_IRQ; i++) begin
         mip_word[IRQ_POS[i]] = irq_pending[i];
         mie_word[IRQ_POS[i]] = irq_enable[i];
      end
   end

   // MPP reads as machine mode, all else zero
   always_comb begin
      mstatus_word                      = '0;
      mstatus_word[MSTATUS_MIE_POS]     = mstatus_mie;
      mstatus_word[MSTATUS_MPIE_POS]    = mstatus_mpie;
      mstatus_word[MSTATUS_MPP_POS[0]]  = 1'b1;
      mstatus_word[MSTATUS_MPP_POS[1]]  = 1'b1;
   end

   // ========================================
   // Source select
   // ========================================

   logic [3:0]      region;
   logic [XLEN-1:0] sel_data;
   logic            rd_stb;

   assign region = req.addr[REGION_MSB:REGION_LSB];
   assign rd_stb = req.stb & ~req.we; // Writes get no response

   always_comb begin
      unique case (region)
         REGION_IO:      sel_data = io_data;
         REGION_MIP:     sel_data = mip_word;
         REGION_MIE:     sel_data = mie_word;
         REGION_MSTATUS: sel_data = mstatus_word;
         default:        sel_data = sram_data; // Lower regions are all SRAM
      endcase
   end

   // ========================================
   // Response register
   // ========================================

   logic            rsp_valid;
   logic [XLEN-1:0] rsp_data;

   // Valid follows every read strobe by exactly one cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= rd_stb;
      end
   end

   // Data held between reads
   always_ff @(posedge clk) begin
      if (rd_stb) begin
         rsp_data <= sel_data;
      end
   end

   assign rsp = '{valid: rsp_valid, data: rsp_data};

endmodule

// File: verilog/sysreg_decode.sv
`timescale 1ns/1ps

module sysreg_decode import rdpath_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  bus_req_t           req,
   input  logic [NUM_IRQ-1:0] irq_enable,  // Gathered from the cells
   input  logic [NUM_IRQ-1:0] irq_pending, // Gathered from the cells
   output logic [NUM_IRQ-1:0] en_wr,       // MIE write strobe per cell
   output logic [NUM_IRQ-1:0] pend_wr,     // MIP write strobe per cell
   output logic [NUM_IRQ-1:0] wbits,       // Write data at IRQ_POS
   output logic               mstatus_mie,
   output logic               mstatus_mpie,
   output logic               sysreg_ack,
   output logic               irq_req
);

   // ========================================
   // Region decode
   // ========================================

   logic [3:0] region;
   logic       hit_mip;
   logic       hit_mie;
   logic       hit_mstatus;
   logic       wr;

   assign region = req.addr[REGION_MSB:REGION_LSB];

   assign hit_mip     = (region == REGION_MIP);
   assign hit_mie     = (region == REGION_MIE);
   assign hit_mstatus = (region == REGION_MSTATUS);

   assign wr = req.stb & req.we; // Any write strobe

   // Registers answer in the strobe cycle, no wait states
   assign sysreg_ack = req.stb & (hit_mip | hit_mie | hit_mstatus);

   // ========================================
   // Cell write steering
   // ========================================

   // Same strobe to every cell, each takes its own data bit
   assign en_wr   = {NUM_IRQ{wr & hit_mie}};
   assign pend_wr = {NUM_IRQ{wr & hit_mip}};

   for (genvar i = 0; i < NUM_IRQ; i++) begin : g_wbits
      assign wbits[i] = req.wdata[IRQ_POS[i]]; // Pick bit at source position
   end

   // ========================================
   // MSTATUS
   // ========================================

   // Only MIE and MPIE are writable
   // MPP is constant and lives in the read mux
   always_ff @(posedge clk) begin
      if (rst) begin
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
      end else if (wr && hit_mstatus) begin
         mstatus_mie  <= req.wdata[MSTATUS_MIE_POS];
         mstatus_mpie <= req.wdata[MSTATUS_MPIE_POS];
      end
   end

   // ========================================
   // Interrupt request
   // ========================================

   logic any_armed;

   // Some source both enabled and pending
   assign any_armed = |(irq_enable & irq_pending);

   // Gated by the global enable, purely from register state
   assign irq_req = mstatus_mie & any_armed;

endmodule

// File: verilog/irq_cell.sv
`timescale 1ns/1ps

module irq_cell (
   input  logic clk,
   input  logic rst,
   input  logic irq_event, // Set pulse from the source
   input  logic en_wr,     // MIE write strobe
   input  logic pend_wr,   // MIP write strobe
   input  logic wbit,      // Write data bit at this source's position
   output logic enable,
   output logic pending
);

   // Enable flop, software owned
   always_ff @(posedge clk) begin
      if (rst) begin
         enable <= 1'b0;
      end else if (en_wr) begin
         enable <= wbit;
      end
   end

   // Pending flop
   // An event in the same cycle as a write of zero wins
   always_ff @(posedge clk) begin
      if (rst) begin
         pending <= 1'b0;
      end else if (irq_event) begin
         pending <= 1'b1; // Set has priority
      end else if (pend_wr) begin
         pending <= wbit; // Software may set or clear
      end
   end

endmodule

// File: verilog/rdpath_pkg.sv
package rdpath_pkg;

   // ========================================
   // Widths
   // ========================================

   localparam int XLEN    = 32; // Data and address width
   localparam int NUM_IRQ = 5;  // Software, timer, external, time incr, retired instr

   // Region field in the address
   localparam int REGION_MSB = 30;
   localparam int REGION_LSB = 27;

   // ========================================
   // Region codes, addr[30:27]
   // ========================================

   localparam logic [3:0] REGION_IO      = 4'b1100; // External input port
   localparam logic [3:0] REGION_MIP     = 4'b1101;
   localparam logic [3:0] REGION_MIE     = 4'b1110;
   localparam logic [3:0] REGION_MSTATUS = 4'b1111;
   // Anything else goes to SRAM

   // ========================================
   // Bit positions
   // ========================================

   // Same layout in MIP and MIE, indexed by source number
   localparam int IRQ_POS [NUM_IRQ] = '{3, 7, 11, 16, 17};

   localparam int MSTATUS_MIE_POS  = 3;
   localparam int MSTATUS_MPIE_POS = 7;
   localparam int MSTATUS_MPP_POS [2] = '{11, 12}; // Hardwired to machine mode

   // Bus strobe from the master, one cycle per access
   typedef struct packed {
      logic            stb;   // Access strobe
      logic            we;    // Write enable
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] wdata;
   } bus_req_t;

   // Registered read result, one cycle after the strobe
   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] data;
   } rd_rsp_t;

endpackage
